/* alu_branch.sv */
`timescale 1ns/1ns

`include "rv_consts.svh"

module alu_branch (
    input  rv_isa_pkg::xword_t       pc_i,
    input  rv_isa_pkg::xword_t       rs1_data_i,
    input  rv_isa_pkg::xword_t       rs2_data_i,
    input  rv_isa_pkg::xword_t       imm_i,
    input  core_ctrl_pkg::op1_sel_e  op1_sel_i,
    input  core_ctrl_pkg::op2_sel_e  op2_sel_i,
    input  rv_isa_pkg::alu_op_e      alu_op_i,
    input  rv_isa_pkg::br_cmp_e      br_cmp_i,
    output rv_isa_pkg::xword_t       result_o,
    output logic                     br_taken_o
);
    import rv_isa_pkg::*;
    import core_ctrl_pkg::*;

    xword_t     op1, op2, sum;
    logic [4:0] shamt;

    always_comb begin
        case (op1_sel_i)
            OP1_PC:   op1 = pc_i;
            OP1_ZERO: op1 = '0;
            default:  op1 = rs1_data_i;
        endcase
    end

    assign op2   = (op2_sel_i == OP2_IMM) ? imm_i : rs2_data_i;
    assign sum   = op1 + op2;
    assign shamt = op2[4:0];

    always_comb begin
        case (alu_op_i)
            ALU_ADD:      result_o = sum;
            ALU_SUB:      result_o = op1 - op2;
            ALU_AND:      result_o = op1 & op2;
            ALU_OR:       result_o = op1 | op2;
            ALU_XOR:      result_o = op1 ^ op2;
            ALU_SLL:      result_o = op1 << shamt;
            ALU_SRL:      result_o = op1 >> shamt;
            ALU_SRA:      result_o = $unsigned($signed(op1) >>> shamt);
            ALU_SLT:      result_o = xword_t'($signed(op1) < $signed(op2));
            ALU_SLTU:     result_o = xword_t'(op1 < op2);
            ALU_JALR_ADD: result_o = {sum[`RV_XLEN-1:1], 1'b0};
            default:      result_o = '0;
        endcase
    end

    // compare always on the register values
    always_comb begin
        case (br_cmp_i)
            BR_EQ:   br_taken_o = rs1_data_i == rs2_data_i;
            BR_NE:   br_taken_o = rs1_data_i != rs2_data_i;
            BR_LT:   br_taken_o = $signed(rs1_data_i) < $signed(rs2_data_i);
            BR_GE:   br_taken_o = $signed(rs1_data_i) >= $signed(rs2_data_i);
            BR_LTU:  br_taken_o = rs1_data_i < rs2_data_i;
            BR_GEU:  br_taken_o = rs1_data_i >= rs2_data_i;
            default: br_taken_o = 1'b0;
        endcase
    end

endmodule

/* compile.f */
+incdir+.
rv_isa_pkg.sv
core_ctrl_pkg.sv
inst_decoder.sv
reg_file.sv
alu_branch.sv
core_sequencer.sv
rv_core.sv
tb_clock_gen.sv
tb_rv_core.sv

/* core_ctrl_pkg.sv */
package core_ctrl_pkg;

    typedef enum logic [1:0] {
        OP1_RS1,
        OP1_PC,
        OP1_ZERO   // lui
    } op1_sel_e;

    typedef enum logic {
        OP2_RS2,
        OP2_IMM
    } op2_sel_e;

    typedef enum logic [1:0] {
        WB_ALU,
        WB_MEM,
        WB_PC4     // link address for jal / jalr
    } wb_sel_e;

    typedef enum logic [1:0] {
        MEM_NONE,
        MEM_LOAD,
        MEM_STORE
    } mem_op_e;

    typedef enum logic [1:0] {
        ST_FETCH,
        ST_EXECUTE,
        ST_MEMORY,
        ST_HALT
    } seq_state_e;

endpackage

/* core_sequencer.sv */
`timescale 1ns/1ns

`include "rv_consts.svh"

module core_sequencer (
    input  logic                     clk,
    input  logic                     rst_n,
    // instruction bus, wishbone classic
    output logic                     ibus_cyc_o,
    output logic                     ibus_stb_o,
    output rv_isa_pkg::xword_t       ibus_adr_o,
    input  rv_isa_pkg::xword_t       ibus_dat_i,
    input  logic                     ibus_ack_i,
    // data bus, wishbone classic
    output logic                     dbus_cyc_o,
    output logic                     dbus_stb_o,
    output logic                     dbus_we_o,
    output rv_isa_pkg::xword_t       dbus_adr_o,
    output rv_isa_pkg::xword_t       dbus_dat_o,
    input  rv_isa_pkg::xword_t       dbus_dat_i,
    input  logic                     dbus_ack_i,
    input  rv_isa_pkg::xword_t       imm_i,
    input  rv_isa_pkg::xword_t       alu_result_i,
    input  logic                     br_taken_i,
    input  logic                     jump_i,
    input  core_ctrl_pkg::wb_sel_e   wb_sel_i,
    input  core_ctrl_pkg::mem_op_e   mem_op_i,
    input  logic                     rf_wen_i,
    input  rv_isa_pkg::xword_t       rs2_data_i,
    output rv_isa_pkg::xword_t       inst_o,
    output rv_isa_pkg::xword_t       pc_o,
    output logic                     rf_wen_o,
    output rv_isa_pkg::xword_t       rf_data_o,
    output logic                     exit_o
);
    import rv_isa_pkg::*;
    import core_ctrl_pkg::*;

    seq_state_e state;
    xword_t     pc, pc_plus4, inst;
    logic       exec_only;

    assign pc_plus4  = pc + 32'd4;
    assign exec_only = (mem_op_i == MEM_NONE);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state      <= ST_FETCH;
            pc         <= `RV_RESET_PC;
            inst       <= '0;  // decodes as nop
            ibus_cyc_o <= 1'b0;
            ibus_stb_o <= 1'b0;
            dbus_cyc_o <= 1'b0;
            dbus_stb_o <= 1'b0;
            dbus_we_o  <= 1'b0;
        end else begin
            case (state)
                ST_FETCH: begin
                    if (!ibus_cyc_o) begin
                        if (pc == `RV_EXIT_PC) begin
                            state <= ST_HALT;
                        end else begin
                            ibus_cyc_o <= 1'b1;
                            ibus_stb_o <= 1'b1;
                        end
                    end else if (ibus_ack_i) begin
                        inst       <= ibus_dat_i;
                        ibus_cyc_o <= 1'b0;
                        ibus_stb_o <= 1'b0;
                        state      <= ST_EXECUTE;
                    end
                end
                ST_EXECUTE: begin
                    if (exec_only) begin
                        if (br_taken_i)
                            pc <= pc + imm_i;
                        else if (jump_i)
                            pc <= alu_result_i;
                        else
                            pc <= pc_plus4;
                        state <= ST_FETCH;
                    end else begin
                        dbus_cyc_o <= 1'b1;
                        dbus_stb_o <= 1'b1;
                        dbus_we_o  <= (mem_op_i == MEM_STORE);
                        state      <= ST_MEMORY;
                    end
                end
                ST_MEMORY: begin
                    if (dbus_ack_i) begin
                        dbus_cyc_o <= 1'b0;
                        dbus_stb_o <= 1'b0;
                        dbus_we_o  <= 1'b0;
                        pc         <= pc_plus4;
                        state      <= ST_FETCH;
                    end
                end
                default: ;  // halted until reset
            endcase
        end
    end

    // rs1, rs2 and inst stay put while the data cycle is open
    assign ibus_adr_o = pc;
    assign dbus_adr_o = {alu_result_i[`RV_XLEN-1:2], 2'b00};
    assign dbus_dat_o = rs2_data_i;

    assign inst_o = inst;
    assign pc_o   = pc;
    assign exit_o = (state == ST_HALT);

    assign rf_wen_o = rf_wen_i && ((state == ST_EXECUTE && exec_only)
                                || (state == ST_MEMORY && dbus_ack_i));

    always_comb begin
        case (wb_sel_i)
            WB_MEM:  rf_data_o = dbus_dat_i;  // load data on the ack cycle
            WB_PC4:  rf_data_o = pc_plus4;
            default: rf_data_o = alu_result_i;
        endcase
    end

endmodule

/* inst_decoder.sv */
`timescale 1ns/1ns

module inst_decoder (
    input  rv_isa_pkg::xword_t         inst_i,
    output rv_isa_pkg::reg_addr_t      rs1_addr_o,
    output rv_isa_pkg::reg_addr_t      rs2_addr_o,
    output rv_isa_pkg::reg_addr_t      rd_addr_o,
    output rv_isa_pkg::xword_t         imm_o,
    output rv_isa_pkg::alu_op_e        alu_op_o,
    output rv_isa_pkg::br_cmp_e        br_cmp_o,
    output core_ctrl_pkg::op1_sel_e    op1_sel_o,
    output core_ctrl_pkg::op2_sel_e    op2_sel_o,
    output core_ctrl_pkg::wb_sel_e     wb_sel_o,
    output core_ctrl_pkg::mem_op_e     mem_op_o,
    output logic                       rf_wen_o,
    output logic                       jump_o
);
    import rv_isa_pkg::*;
    import core_ctrl_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    xword_t     imm_i, imm_s, imm_b, imm_u, imm_j;
    logic       op_legal, op_imm_legal;

    function automatic alu_op_e alu_from_funct3(input logic [2:0] f3, input logic alt);
        case (f3)
            F3_ADD:  return alt ? ALU_SUB : ALU_ADD;
            F3_SLL:  return ALU_SLL;
            F3_SLT:  return ALU_SLT;
            F3_SLTU: return ALU_SLTU;
            F3_XOR:  return ALU_XOR;
            F3_SR:   return alt ? ALU_SRA : ALU_SRL;
            F3_OR:   return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    assign opcode     = inst_i[6:0];
    assign funct3     = inst_i[14:12];
    assign funct7     = inst_i[31:25];
    assign rs1_addr_o = inst_i[19:15];
    assign rs2_addr_o = inst_i[24:20];
    assign rd_addr_o  = inst_i[11:7];

    assign imm_i = {{20{inst_i[31]}}, inst_i[31:20]};
    assign imm_s = {{20{inst_i[31]}}, inst_i[31:25], inst_i[11:7]};
    assign imm_b = {{20{inst_i[31]}}, inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};
    assign imm_u = {inst_i[31:12], 12'b0};
    assign imm_j = {{12{inst_i[31]}}, inst_i[19:12], inst_i[20], inst_i[30:21], 1'b0};

    // funct7 may only be F7_ALT for sub / sra
    assign op_legal = (funct7 == F7_BASE)
                   || (funct7 == F7_ALT && (funct3 == F3_ADD || funct3 == F3_SR));
    assign op_imm_legal = (funct3 != F3_SLL && funct3 != F3_SR)
                       || funct7 == F7_BASE
                       || (funct7 == F7_ALT && funct3 == F3_SR);

    always_comb begin
        alu_op_o  = ALU_NONE;
        br_cmp_o  = BR_NONE;
        op1_sel_o = OP1_RS1;
        op2_sel_o = OP2_IMM;
        wb_sel_o  = WB_ALU;
        mem_op_o  = MEM_NONE;
        rf_wen_o  = 1'b0;
        jump_o    = 1'b0;
        imm_o     = imm_i;
        case (opcode)
            OPC_OP: begin
                op2_sel_o = OP2_RS2;
                if (op_legal) begin
                    alu_op_o = alu_from_funct3(funct3, funct7 == F7_ALT);
                    rf_wen_o = 1'b1;
                end
            end
            OPC_OP_IMM: begin
                if (op_imm_legal) begin
                    alu_op_o = alu_from_funct3(funct3, funct3 == F3_SR && funct7 == F7_ALT);
                    rf_wen_o = 1'b1;
                end
            end
            OPC_LOAD: begin
                if (funct3 == F3_WORD) begin
                    alu_op_o = ALU_ADD;
                    mem_op_o = MEM_LOAD;
                    wb_sel_o = WB_MEM;
                    rf_wen_o = 1'b1;
                end
            end
            OPC_STORE: begin
                imm_o = imm_s;
                if (funct3 == F3_WORD) begin
                    alu_op_o = ALU_ADD;
                    mem_op_o = MEM_STORE;
                end
            end
            OPC_BRANCH: begin
                imm_o     = imm_b;  // target is pc + imm
                op2_sel_o = OP2_RS2;
                case (funct3)
                    F3_BEQ:  br_cmp_o = BR_EQ;
                    F3_BNE:  br_cmp_o = BR_NE;
                    F3_BLT:  br_cmp_o = BR_LT;
                    F3_BGE:  br_cmp_o = BR_GE;
                    F3_BLTU: br_cmp_o = BR_LTU;
                    F3_BGEU: br_cmp_o = BR_GEU;
                    default: br_cmp_o = BR_NONE;
                endcase
            end
            OPC_JAL: begin
                imm_o     = imm_j;
                op1_sel_o = OP1_PC;
                alu_op_o  = ALU_ADD;
                wb_sel_o  = WB_PC4;
                rf_wen_o  = 1'b1;
                jump_o    = 1'b1;
            end
            OPC_JALR: begin
                if (funct3 == F3_JALR) begin
                    alu_op_o = ALU_JALR_ADD;
                    wb_sel_o = WB_PC4;
                    rf_wen_o = 1'b1;
                    jump_o   = 1'b1;
                end
            end
            OPC_LUI: begin
                imm_o     = imm_u;
                op1_sel_o = OP1_ZERO;
                alu_op_o  = ALU_ADD;
                rf_wen_o  = 1'b1;
            end
            OPC_AUIPC: begin
                imm_o     = imm_u;
                op1_sel_o = OP1_PC;
                alu_op_o  = ALU_ADD;
                rf_wen_o  = 1'b1;
            end
            default: ;  // unknown encoding, nop
        endcase
    end

endmodule

/* reg_file.sv */
`timescale 1ns/1ns

`include "rv_consts.svh"

module reg_file (
    input  logic                  clk,
    input  logic                  rst_n,
    input  rv_isa_pkg::reg_addr_t rs1_addr_i,
    input  rv_isa_pkg::reg_addr_t rs2_addr_i,
    input  rv_isa_pkg::reg_addr_t rd_addr_i,
    input  rv_isa_pkg::xword_t    rd_data_i,
    input  logic                  wen_i,
    output rv_isa_pkg::xword_t    rs1_data_o,
    output rv_isa_pkg::xword_t    rs2_data_o,
    output rv_isa_pkg::xword_t    gp_o
);
    import rv_isa_pkg::*;

    xword_t regs [`RV_REG_COUNT];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `RV_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wen_i && rd_addr_i != '0) begin
            regs[rd_addr_i] <= rd_data_i;
        end
    end

    // x0 always reads zero
    assign rs1_data_o = (rs1_addr_i == '0) ? '0 : regs[rs1_addr_i];
    assign rs2_data_o = (rs2_addr_i == '0) ? '0 : regs[rs2_addr_i];
    assign gp_o       = regs[`RV_GP_INDEX];

endmodule

/* run_sim.sh */
#!/bin/sh
# build and run the rv_core testbench, pass only if the log holds the pass line
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log
verilator --binary --timing --top-module tb_rv_core -f compile.f -o sim_rv_core \
    > build.log 2>&1 \
    && ./obj_dir/sim_rv_core > sim.log 2>&1 \
    || { echo "build or simulation failed"; cat build.log sim.log 2>/dev/null; exit 1; }
cat sim.log
grep -q "^TEST OK$" sim.log && exit 0 || exit 1

/* rv_consts.svh */
`ifndef RV_CONSTS_SVH
`define RV_CONSTS_SVH

// machine word and register file geometry
`define RV_XLEN        32
`define RV_REG_COUNT   32
`define RV_REG_ADDR_W  5

`define RV_RESET_PC    32'h0000_0000
`define RV_EXIT_PC     32'h0000_0044  // fetch here ends the program

`define RV_GP_INDEX    3

`endif

/* rv_core.sv */
`timescale 1ns/1ns

module rv_core (
    input  logic               clk,
    input  logic               rst_n,
    output logic               ibus_cyc_o,
    output logic               ibus_stb_o,
    output rv_isa_pkg::xword_t ibus_adr_o,
    input  rv_isa_pkg::xword_t ibus_dat_i,
    input  logic               ibus_ack_i,
    output logic               dbus_cyc_o,
    output logic               dbus_stb_o,
    output logic               dbus_we_o,
    output rv_isa_pkg::xword_t dbus_adr_o,
    output rv_isa_pkg::xword_t dbus_dat_o,
    input  rv_isa_pkg::xword_t dbus_dat_i,
    input  logic               dbus_ack_i,
    output logic               exit_o,
    output rv_isa_pkg::xword_t gp_o
);
    import rv_isa_pkg::*;
    import core_ctrl_pkg::*;

    xword_t    inst, pc, imm, rs1_data, rs2_data, alu_result, rf_data;
    reg_addr_t rs1_addr, rs2_addr, rd_addr;
    alu_op_e   alu_op;
    br_cmp_e   br_cmp;
    op1_sel_e  op1_sel;
    op2_sel_e  op2_sel;
    wb_sel_e   wb_sel;
    mem_op_e   mem_op;
    logic      dec_rf_wen, rf_wen, jump, br_taken;

    inst_decoder u_decoder (
        .inst_i     (inst),
        .rs1_addr_o (rs1_addr),
        .rs2_addr_o (rs2_addr),
        .rd_addr_o  (rd_addr),
        .imm_o      (imm),
        .alu_op_o   (alu_op),
        .br_cmp_o   (br_cmp),
        .op1_sel_o  (op1_sel),
        .op2_sel_o  (op2_sel),
        .wb_sel_o   (wb_sel),
        .mem_op_o   (mem_op),
        .rf_wen_o   (dec_rf_wen),
        .jump_o     (jump)
    );

    reg_file u_reg_file (
        .clk        (clk),
        .rst_n      (rst_n),
        .rs1_addr_i (rs1_addr),
        .rs2_addr_i (rs2_addr),
        .rd_addr_i  (rd_addr),
        .rd_data_i  (rf_data),
        .wen_i      (rf_wen),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data),
        .gp_o       (gp_o)
    );

    alu_branch u_alu_branch (
        .pc_i       (pc),
        .rs1_data_i (rs1_data),
        .rs2_data_i (rs2_data),
        .imm_i      (imm),
        .op1_sel_i  (op1_sel),
        .op2_sel_i  (op2_sel),
        .alu_op_i   (alu_op),
        .br_cmp_i   (br_cmp),
        .result_o   (alu_result),
        .br_taken_o (br_taken)
    );

    core_sequencer u_sequencer (
        .clk          (clk),
        .rst_n        (rst_n),
        .ibus_cyc_o   (ibus_cyc_o),
        .ibus_stb_o   (ibus_stb_o),
        .ibus_adr_o   (ibus_adr_o),
        .ibus_dat_i   (ibus_dat_i),
        .ibus_ack_i   (ibus_ack_i),
        .dbus_cyc_o   (dbus_cyc_o),
        .dbus_stb_o   (dbus_stb_o),
        .dbus_we_o    (dbus_we_o),
        .dbus_adr_o   (dbus_adr_o),
        .dbus_dat_o   (dbus_dat_o),
        .dbus_dat_i   (dbus_dat_i),
        .dbus_ack_i   (dbus_ack_i),
        .imm_i        (imm),
        .alu_result_i (alu_result),
        .br_taken_i   (br_taken),
        .jump_i       (jump),
        .wb_sel_i     (wb_sel),
        .mem_op_i     (mem_op),
        .rf_wen_i     (dec_rf_wen),
        .rs2_data_i   (rs2_data),
        .inst_o       (inst),
        .pc_o         (pc),
        .rf_wen_o     (rf_wen),
        .rf_data_o    (rf_data),
        .exit_o       (exit_o)
    );

endmodule

/* rv_core_testdata.hex */
// words 0-16: program image, one instruction per word
// @20: store address/data pairs, @30: final gp then store count
FFD00093
12345137
00001217
401102B3
4010D313
0000A3B3
10502023
10002403
10802223
00130313
FE031EE3
00C0056F
00A181B3
00C0006F
004381B3
00050067
10302423
@20
00000100
12345003
00000104
12345003
00000108
00001039
@30
00001039
00000003

/* rv_isa_pkg.sv */
package rv_isa_pkg;

`include "rv_consts.svh"

    typedef logic [`RV_XLEN-1:0] xword_t;
    typedef logic [`RV_REG_ADDR_W-1:0] reg_addr_t;

    // major opcodes still supported
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111
    } opcode_e;

    typedef enum logic [2:0] {
        F3_ADD  = 3'b000,
        F3_SLL  = 3'b001,
        F3_SLT  = 3'b010,
        F3_SLTU = 3'b011,
        F3_XOR  = 3'b100,
        F3_SR   = 3'b101,  // srl and sra
        F3_OR   = 3'b110,
        F3_AND  = 3'b111
    } funct3_alu_e;

    typedef enum logic [2:0] {
        F3_BEQ  = 3'b000,
        F3_BNE  = 3'b001,
        F3_BLT  = 3'b100,
        F3_BGE  = 3'b101,
        F3_BLTU = 3'b110,
        F3_BGEU = 3'b111
    } funct3_br_e;

    typedef enum logic [2:0] {
        F3_JALR = 3'b000,
        F3_WORD = 3'b010   // lw / sw
    } funct3_misc_e;

    typedef enum logic [6:0] {
        F7_BASE = 7'h00,
        F7_ALT  = 7'h20    // sub, sra
    } funct7_e;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
        ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU,
        ALU_JALR_ADD, ALU_NONE
    } alu_op_e;

    typedef enum logic [2:0] {
        BR_NONE, BR_EQ, BR_NE, BR_LT, BR_GE, BR_LTU, BR_GEU
    } br_cmp_e;

endpackage

/* tb_clock_gen.sv */
`timescale 1ns/1ns

module tb_clock_gen (
    output logic clk_o,
    output logic rst_n_o
);
    initial begin
        clk_o   = 1'b0;
        rst_n_o <= 1'b0;
        repeat (3) @(posedge clk_o);
        @(negedge clk_o);
        rst_n_o <= 1'b1;  // released on a falling edge
    end

    always #10 clk_o = ~clk_o;  // 20 ns period

endmodule

/* tb_rv_core.sv */
`timescale 1ns/1ns

module tb_rv_core;

    logic        clk, rst_n;
    logic        ibus_cyc, ibus_stb, ibus_ack;
    logic [31:0] ibus_adr, ibus_dat;
    logic        dbus_cyc, dbus_stb, dbus_we, dbus_ack;
    logic [31:0] dbus_adr, dbus_dat_w, dbus_dat_r;
    logic        exit_flag;
    logic [31:0] gp;

    logic [31:0] tdata [64];
    logic [31:0] imem [32];
    logic [31:0] dmem [128];

    integer seed;
    int     i_wait, d_wait;
    int     error_count, timeout_count, store_count;
    logic   first_fetch_seen;
    logic   ok;

    // previous-cycle bus state for the hold check
    logic        prev_istb, prev_iack, prev_dstb, prev_dack, prev_dwe;
    logic [31:0] prev_iadr, prev_dadr, prev_ddat;

    tb_clock_gen u_clock_gen (
        .clk_o   (clk),
        .rst_n_o (rst_n)
    );

    rv_core UUT (
        .clk        (clk),
        .rst_n      (rst_n),
        .ibus_cyc_o (ibus_cyc),
        .ibus_stb_o (ibus_stb),
        .ibus_adr_o (ibus_adr),
        .ibus_dat_i (ibus_dat),
        .ibus_ack_i (ibus_ack),
        .dbus_cyc_o (dbus_cyc),
        .dbus_stb_o (dbus_stb),
        .dbus_we_o  (dbus_we),
        .dbus_adr_o (dbus_adr),
        .dbus_dat_o (dbus_dat_w),
        .dbus_dat_i (dbus_dat_r),
        .dbus_ack_i (dbus_ack),
        .exit_o     (exit_flag),
        .gp_o       (gp)
    );

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("CHECK FAILED %s: expected %h, actual %h", name, expected, actual);
            error_count++;
        end
    endtask

    task automatic finish_run();
        $display("errors: %0d check failures, %0d timeouts, %0d stores seen",
                 error_count, timeout_count, store_count);
        if (error_count == 0 && timeout_count == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    endtask

    task automatic wait_reset_release(output logic done);
        int n;
        n = 0;
        done = 1'b0;
        while (!done && n < 20) begin
            @(negedge clk);
            if (rst_n) done = 1'b1;
            n++;
        end
        if (!done) begin
            $display("timeout: reset was never released");
            timeout_count++;
        end
    endtask

    task automatic wait_exit(output logic done);
        int n;
        n = 0;
        done = 1'b0;
        while (!done && n < 3000) begin
            @(negedge clk);
            if (exit_flag) done = 1'b1;
            n++;
        end
        if (!done) begin
            $display("timeout: the core never reached the exit address");
            timeout_count++;
        end
    endtask

    task automatic watch_idle_after_exit();
        for (int n = 0; n < 50; n++) begin
            @(negedge clk);
            check_value("idle ibus_cyc", 32'd0, {31'd0, ibus_cyc});
            check_value("idle ibus_stb", 32'd0, {31'd0, ibus_stb});
            check_value("idle dbus_cyc", 32'd0, {31'd0, dbus_cyc});
            check_value("idle dbus_stb", 32'd0, {31'd0, dbus_stb});
            check_value("idle exit", 32'd1, {31'd0, exit_flag});
        end
    endtask

    // hold checks first, then both memory models, all on the falling edge
    always @(negedge clk) begin
        if (!rst_n) begin
            check_value("reset ibus_cyc", 32'd0, {31'd0, ibus_cyc});
            check_value("reset ibus_stb", 32'd0, {31'd0, ibus_stb});
            check_value("reset dbus_cyc", 32'd0, {31'd0, dbus_cyc});
            check_value("reset dbus_stb", 32'd0, {31'd0, dbus_stb});
            check_value("reset exit", 32'd0, {31'd0, exit_flag});
        end else begin
            if (ibus_stb && !first_fetch_seen) begin
                check_value("first fetch address", 32'd0, ibus_adr);
                first_fetch_seen = 1'b1;
            end
            if (prev_istb && !prev_iack && ibus_stb)
                check_value("ibus adr hold", prev_iadr, ibus_adr);
            if (prev_dstb && !prev_dack && dbus_stb) begin
                check_value("dbus adr hold", prev_dadr, dbus_adr);
                check_value("dbus we hold", {31'd0, prev_dwe}, {31'd0, dbus_we});
                check_value("dbus dat hold", prev_ddat, dbus_dat_w);
            end

            // instruction memory
            if (ibus_ack) begin
                ibus_ack = 1'b0;
            end else if (ibus_cyc && ibus_stb) begin
                if (i_wait == 0) begin
                    ibus_dat = imem[ibus_adr[6:2]];
                    ibus_ack = 1'b1;
                end else begin
                    i_wait--;
                end
            end else begin
                i_wait = {$random(seed)} % 4;
            end

            // data memory, stores checked when acked
            if (dbus_ack) begin
                dbus_ack = 1'b0;
            end else if (dbus_cyc && dbus_stb) begin
                if (d_wait == 0) begin
                    if (dbus_we) begin
                        if (store_count < 8) begin
                            check_value("store address", tdata[32 + 2*store_count], dbus_adr);
                            check_value("store data", tdata[33 + 2*store_count], dbus_dat_w);
                        end else begin
                            $display("more stores than the data file lists");
                            error_count++;
                        end
                        dmem[dbus_adr[8:2]] = dbus_dat_w;
                        store_count++;
                    end else begin
                        dbus_dat_r = dmem[dbus_adr[8:2]];
                    end
                    dbus_ack = 1'b1;
                end else begin
                    d_wait--;
                end
            end else begin
                d_wait = {$random(seed)} % 4;
            end
        end
        prev_istb = ibus_stb;
        prev_iack = ibus_ack;
        prev_iadr = ibus_adr;
        prev_dstb = dbus_stb;
        prev_dack = dbus_ack;
        prev_dadr = dbus_adr;
        prev_dwe  = dbus_we;
        prev_ddat = dbus_dat_w;
    end

    initial begin
        seed             = 32'h50da_2799;
        ibus_dat         = '0;
        ibus_ack         = 1'b0;
        dbus_dat_r       = '0;
        dbus_ack         = 1'b0;
        i_wait           = 0;
        d_wait           = 0;
        error_count      = 0;
        timeout_count    = 0;
        store_count      = 0;
        first_fetch_seen = 1'b0;
        prev_istb        = 1'b0;
        prev_iack        = 1'b0;
        prev_dstb        = 1'b0;
        prev_dack        = 1'b0;
        for (int k = 0; k < 64; k++) tdata[k] = '0;
        $readmemh("rv_core_testdata.hex", tdata);
        for (int k = 0; k < 32; k++) imem[k] = tdata[k];
        for (int k = 0; k < 128; k++) begin
            dmem[k] = (k < 32) ? tdata[k] : (32'hc0de_0000 ^ (k << 2));  // program copy below
        end

        wait_reset_release(ok);
        if (ok) wait_exit(ok);
        if (ok) begin
            check_value("final gp", tdata[48], gp);
            check_value("store count", tdata[49], store_count);
            watch_idle_after_exit();
        end
        finish_run();
    end

endmodule
